//--- src/cpuPkg.sv
// Shared widths, opcode, ALU operation, bus source and register select types
`default_nettype none

package cpuPkg;

  localparam int wordW   = 32;  // Data word width
  localparam int cWidth  = 15;  // Constant field in IR[14:0]
  localparam int regIdxW = 4;   // Sixteen general registers

  // Field layout: op[31:27] ra[26:23] rb[22:19] rc[18:15] c[14:0]
  typedef enum logic [4:0] {
    opLd   = 5'd0,   // Ra <- mem[Rb + C], R0 base reads zero
    opSt   = 5'd1,   // mem[Rb + C] <- Ra, R0 base reads zero
    opAddi = 5'd2,   // Ra <- Rb + C
    opAdd  = 5'd3,   // Ra <- Rb + Rc
    opSub  = 5'd4,   // Ra <- Rb - Rc
    opAnd  = 5'd5,
    opOr   = 5'd6,
    opShl  = 5'd7,   // Ra <- Rb << Rc[4:0]
    opShr  = 5'd8,   // Logical, by Rc[4:0]
    opMul  = 5'd9,   // HI:LO <- Rb * Rc, signed
    opMfhi = 5'd10,  // Ra <- HI
    opMflo = 5'd11,  // Ra <- LO
    opOut  = 5'd12,  // Output port <- Ra
    opHalt = 5'd31   // Unused codes decode the same way
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluShl, aluShr, aluMul
  } aluOpT;

  typedef enum logic [3:0] {
    srcReg, srcPc, srcMdr, srcZHigh, srcZLow, srcHi, srcLo, srcY, srcConst
  } busSrcT;

  // Which IR register field is addressed
  typedef enum logic [1:0] {
    selNone, selRa, selRb, selRc
  } regSelT;

endpackage

`default_nettype wire

//--- src/stepCounter.sv
// Microstep counter with clear and advance
`timescale 1ns/100ps
`default_nettype none

module stepCounter (
  input  logic       clock,
  input  logic       rstN,
  input  logic       advance,
  input  logic       clear,
  output logic [2:0] step
);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      step <= '0;
    end else if (clear) begin  // Instruction boundary wins
      step <= '0;
    end else if (advance) begin
      step <= step + 3'd1;
    end
  end

endmodule

`default_nettype wire

//--- src/controlUnit.sv
// CPU control FSM: handshakes, fetch sequence and per-opcode execute steps
`timescale 1ns/100ps
`default_nettype none

module controlUnit import cpuPkg::*; (
  input  logic       clock,
  input  logic       rstN,
  input  logic       loadValid,
  output logic       loadReady,
  input  logic       startValid,
  output logic       startReady,
  input  logic       outReady,
  output logic       outValid,
  input  logic       doneReady,
  output logic       doneValid,
  input  opcodeT     opcode,
  input  logic [2:0] step,
  output logic       advance,
  output logic       clear,
  output busSrcT     busSrc,
  output regSelT     regInSel,
  output regSelT     regOutSel,
  output aluOpT      aluOp,
  output logic       marIn,
  output logic       mdrIn,
  output logic       mdrRead,
  output logic       memWrite,
  output logic       irIn,
  output logic       pcIn,
  output logic       incPc,
  output logic       yIn,
  output logic       zIn,
  output logic       hiIn,
  output logic       loIn,
  output logic       outIn,
  output logic       loadWrite,
  output logic       startLoad
);

  typedef enum logic [2:0] {sBoot, sIdle, sFetch, sExec, sOutWait, sDone} stateT;

  stateT state, nextState, exitState;
  logic  endInstr;

  // Handshake flags straight from the state register
  assign loadReady  = (state == sIdle);
  assign startReady = (state == sIdle);
  assign outValid   = (state == sOutWait);
  assign doneValid  = (state == sDone);

  function automatic aluOpT aluFor(opcodeT op);
    case (op)
      opSub:   aluFor = aluSub;
      opAnd:   aluFor = aluAnd;
      opOr:    aluFor = aluOr;
      opShl:   aluFor = aluShl;
      opShr:   aluFor = aluShr;
      opMul:   aluFor = aluMul;
      default: aluFor = aluAdd;  // addi and address math
    endcase
  endfunction

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= sBoot;  // Keeps the ready flags low through reset
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    exitState = sFetch;
    endInstr  = 1'b0;
    advance   = 1'b0;
    clear     = 1'b0;
    busSrc    = srcReg;
    regInSel  = selNone;
    regOutSel = selNone;
    aluOp     = aluAdd;
    {marIn, mdrIn, mdrRead, memWrite, irIn, pcIn, incPc} = '0;
    {yIn, zIn, hiIn, loIn, outIn, loadWrite, startLoad} = '0;
    case (state)
      sBoot: nextState = sIdle;
      sIdle: begin
        loadWrite = loadValid;
        if (startValid) begin
          startLoad = 1'b1;
          clear     = 1'b1;
          nextState = sFetch;
        end
      end
      sFetch: begin
        advance = 1'b1;
        case (step)
          3'd0: begin
            busSrc = srcPc;
            marIn  = 1'b1;
            incPc  = 1'b1;
          end
          3'd1: begin
            mdrIn   = 1'b1;
            mdrRead = 1'b1;
          end
          default: begin
            busSrc    = srcMdr;
            irIn      = 1'b1;
            nextState = sExec;
          end
        endcase
      end
      sExec: begin
        case (opcode)
          opAddi, opAdd, opSub, opAnd, opOr, opShl, opShr, opMul: begin
            case (step)
              3'd3: begin
                regOutSel = selRb;
                yIn       = 1'b1;
              end
              3'd4: begin
                busSrc    = (opcode == opAddi) ? srcConst : srcReg;
                regOutSel = selRc;
                aluOp     = aluFor(opcode);
                zIn       = 1'b1;
              end
              3'd5: begin
                busSrc   = srcZLow;
                regInSel = (opcode == opMul) ? selNone : selRa;
                loIn     = (opcode == opMul);
                endInstr = (opcode != opMul);
              end
              default: begin  // mul only
                busSrc   = srcZHigh;
                hiIn     = 1'b1;
                endInstr = 1'b1;
              end
            endcase
          end
          opLd, opSt: begin
            case (step)
              3'd3: begin
                regOutSel = selRb;  // Base, R0 zeroed in the datapath
                yIn       = 1'b1;
              end
              3'd4: begin
                busSrc = srcConst;
                zIn    = 1'b1;
              end
              3'd5: begin
                busSrc = srcZLow;
                marIn  = 1'b1;
              end
              3'd6: begin
                regOutSel = selRa;
                mdrIn     = 1'b1;
                mdrRead   = (opcode == opLd);
              end
              default: begin
                busSrc   = srcMdr;
                regInSel = (opcode == opLd) ? selRa : selNone;
                memWrite = (opcode == opSt);
                endInstr = 1'b1;
              end
            endcase
          end
          opMfhi, opMflo: begin
            busSrc   = (opcode == opMfhi) ? srcHi : srcLo;
            regInSel = selRa;
            endInstr = 1'b1;
          end
          opOut: begin
            regOutSel = selRa;
            outIn     = 1'b1;
            endInstr  = 1'b1;
            exitState = sOutWait;
          end
          default: begin
            endInstr  = 1'b1;
            exitState = sDone;
          end
        endcase
        if (endInstr) begin
          clear     = 1'b1;
          nextState = exitState;
        end else begin
          advance = 1'b1;
        end
      end
      sOutWait: if (outReady) nextState = sFetch;
      sDone:    if (doneReady) nextState = sIdle;
      default:  nextState = sIdle;
    endcase
  end

endmodule

`default_nettype wire

//--- src/registerFile.sv
// General register file with IR field select, R0 base zeroing and constant sign extension
`timescale 1ns/100ps
`default_nettype none

module registerFile import cpuPkg::*; (
  input  logic             clock,
  input  logic             rstN,
  input  logic [wordW-1:0] ir,
  input  regSelT           regInSel,
  input  regSelT           regOutSel,
  input  logic             baseZero,
  input  logic [wordW-1:0] busIn,
  output logic [wordW-1:0] regOut,
  output logic [wordW-1:0] cExt
);

  logic [wordW-1:0]   regs [2**regIdxW];
  logic [regIdxW-1:0] wrIdx;
  logic [regIdxW-1:0] rdIdx;

  function automatic logic [regIdxW-1:0] fieldIdx(regSelT sel, logic [wordW-1:0] instr);
    case (sel)
      selRa:   fieldIdx = instr[26:23];
      selRb:   fieldIdx = instr[22:19];
      selRc:   fieldIdx = instr[18:15];
      default: fieldIdx = '0;
    endcase
  endfunction

  assign wrIdx = fieldIdx(regInSel, ir);
  assign rdIdx = fieldIdx(regOutSel, ir);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regIdxW; i++) begin
        regs[i] <= '0;
      end
    end else if (regInSel != selNone) begin
      regs[wrIdx] <= busIn;
    end
  end

  // R0 as a base address reads zero whatever it holds
  assign regOut = (baseZero && rdIdx == '0) ? '0 : regs[rdIdx];

  assign cExt = {{(wordW-cWidth){ir[cWidth-1]}}, ir[cWidth-1:0]};

endmodule

`default_nettype wire

//--- src/alu.sv
// Combinational ALU producing a 64-bit result from Y and the bus
`timescale 1ns/100ps
`default_nettype none

module alu import cpuPkg::*; (
  input  logic [wordW-1:0]   a,
  input  logic [wordW-1:0]   b,
  input  aluOpT              aluOp,
  output logic [2*wordW-1:0] result
);

  localparam int shW = $clog2(wordW);

  logic signed [2*wordW-1:0] product;
  logic [shW-1:0]            shAmt;

  assign shAmt   = b[shW-1:0];                 // Only the low bits count
  assign product = $signed(a) * $signed(b);    // Full signed product

  always_comb begin
    case (aluOp)
      aluAdd:  result = {{wordW{1'b0}}, a + b};
      aluSub:  result = {{wordW{1'b0}}, a - b};
      aluAnd:  result = {{wordW{1'b0}}, a & b};
      aluOr:   result = {{wordW{1'b0}}, a | b};
      aluShl:  result = {{wordW{1'b0}}, a << shAmt};
      aluShr:  result = {{wordW{1'b0}}, a >> shAmt};  // Logical
      aluMul:  result = product;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/memoryUnit.sv
// MAR, MDR and synchronous RAM with an external load port
`timescale 1ns/100ps
`default_nettype none

module memoryUnit import cpuPkg::*; #(
  parameter int memAddrW = 9
) (
  input  logic                clock,
  input  logic                rstN,
  input  logic [wordW-1:0]    busIn,
  input  logic                marIn,
  input  logic                mdrIn,
  input  logic                mdrRead,
  input  logic                memWrite,
  input  logic                loadWrite,
  input  logic [memAddrW-1:0] loadAddr,
  input  logic [wordW-1:0]    loadData,
  output logic [wordW-1:0]    mdrOut
);

  logic [wordW-1:0]    ram [2**memAddrW];
  logic [memAddrW-1:0] mar;
  logic [wordW-1:0]    mdr;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      mar <= '0;
    end else if (marIn) begin
      mar <= busIn[memAddrW-1:0];  // Word address from bus low bits
    end
  end

  always_ff @(posedge clock) begin
    if (mdrIn) begin
      mdr <= mdrRead ? ram[mar] : busIn;
    end
  end

  always_ff @(posedge clock) begin
    if (loadWrite) begin
      ram[loadAddr] <= loadData;  // Only while idle
    end else if (memWrite) begin
      ram[mar] <= mdr;
    end
  end

  assign mdrOut = mdr;

endmodule

`default_nettype wire

//--- src/dataPath.sv
// Single-bus datapath: bus mux, PC, IR, Y, Z, HI, LO, output register and submodules
`timescale 1ns/100ps
`default_nettype none

module dataPath import cpuPkg::*; #(
  parameter int memAddrW = 9
) (
  input  logic                clock,
  input  logic                rstN,
  input  busSrcT              busSrc,
  input  regSelT              regInSel,
  input  regSelT              regOutSel,
  input  aluOpT               aluOp,
  input  logic                marIn,
  input  logic                mdrIn,
  input  logic                mdrRead,
  input  logic                memWrite,
  input  logic                irIn,
  input  logic                pcIn,
  input  logic                incPc,
  input  logic                yIn,
  input  logic                zIn,
  input  logic                hiIn,
  input  logic                loIn,
  input  logic                outIn,
  input  logic                loadWrite,
  input  logic                startLoad,
  input  logic [memAddrW-1:0] loadAddr,
  input  logic [wordW-1:0]    loadData,
  input  logic [memAddrW-1:0] startPc,
  output opcodeT              opcode,
  output logic [wordW-1:0]    outData
);

  logic [wordW-1:0]   bus;
  logic [wordW-1:0]   pc, ir, y, hi, lo;
  logic [2*wordW-1:0] z;
  logic [2*wordW-1:0] aluResult;
  logic [wordW-1:0]   regOut, cExt, mdrOut;
  logic               baseZero;

  assign opcode   = opcodeT'(ir[31:27]);
  assign baseZero = (opcode == opLd || opcode == opSt) && (regOutSel == selRb);

  always_comb begin
    case (busSrc)
      srcReg:   bus = regOut;
      srcPc:    bus = pc;
      srcMdr:   bus = mdrOut;
      srcZHigh: bus = z[2*wordW-1:wordW];
      srcZLow:  bus = z[wordW-1:0];
      srcHi:    bus = hi;
      srcLo:    bus = lo;
      srcY:     bus = y;
      srcConst: bus = cExt;
      default:  bus = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
      ir <= '0;
    end else begin
      if (startLoad) begin
        pc <= {{(wordW-memAddrW){1'b0}}, startPc};
      end else if (pcIn) begin
        pc <= bus;
      end else if (incPc) begin
        pc <= pc + 1'b1;  // Word addressed
      end
      if (irIn) ir <= bus;
    end
  end

  always_ff @(posedge clock) begin
    if (yIn)   y       <= bus;
    if (zIn)   z       <= aluResult;
    if (hiIn)  hi      <= bus;
    if (loIn)  lo      <= bus;
    if (outIn) outData <= bus;  // Held until the port accepts it
  end

  registerFile regFile_i (
    .clock, .rstN, .ir, .regInSel, .regOutSel, .baseZero,
    .busIn(bus), .regOut, .cExt
  );

  alu alu_i (
    .a(y), .b(bus), .aluOp, .result(aluResult)
  );

  memoryUnit #(.memAddrW(memAddrW)) mem_i (
    .clock, .rstN, .busIn(bus), .marIn, .mdrIn, .mdrRead, .memWrite,
    .loadWrite, .loadAddr, .loadData, .mdrOut
  );

endmodule

`default_nettype wire

//--- src/cpuTop.sv
// CPU top level joining control FSM, step counter and datapath
`timescale 1ns/100ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
  parameter int memAddrW = 9
) (
  input  logic                clock,
  input  logic                rstN,
  input  logic                loadValid,
  input  logic [memAddrW-1:0] loadAddr,
  input  logic [wordW-1:0]    loadData,
  output logic                loadReady,
  input  logic                startValid,
  input  logic [memAddrW-1:0] startPc,
  output logic                startReady,
  output logic                outValid,
  output logic [wordW-1:0]    outData,
  input  logic                outReady,
  output logic                doneValid,
  input  logic                doneReady
);

  opcodeT     opcode;
  logic [2:0] step;
  logic       advance, clear;
  busSrcT     busSrc;
  regSelT     regInSel, regOutSel;
  aluOpT      aluOp;
  logic       marIn, mdrIn, mdrRead, memWrite, irIn, pcIn, incPc;
  logic       yIn, zIn, hiIn, loIn, outIn, loadWrite, startLoad;

  controlUnit ctrl_i (
    .clock, .rstN, .loadValid, .loadReady, .startValid, .startReady,
    .outReady, .outValid, .doneReady, .doneValid, .opcode, .step,
    .advance, .clear, .busSrc, .regInSel, .regOutSel, .aluOp,
    .marIn, .mdrIn, .mdrRead, .memWrite, .irIn, .pcIn, .incPc,
    .yIn, .zIn, .hiIn, .loIn, .outIn, .loadWrite, .startLoad
  );

  stepCounter step_i (
    .clock, .rstN, .advance, .clear, .step
  );

  dataPath #(.memAddrW(memAddrW)) dp_i (
    .clock, .rstN, .busSrc, .regInSel, .regOutSel, .aluOp,
    .marIn, .mdrIn, .mdrRead, .memWrite, .irIn, .pcIn, .incPc,
    .yIn, .zIn, .hiIn, .loIn, .outIn, .loadWrite, .startLoad,
    .loadAddr, .loadData, .startPc, .opcode, .outData
  );

endmodule

`default_nettype wire

//--- tb/cpuTop_props.sv
// Concurrent handshake assertions for the CPU top-level ports
`timescale 1ns/100ps
`default_nettype none

module cpuTop_props import cpuPkg::*; (
  input logic             clock,
  input logic             rstN,
  input logic             loadReady,
  input logic             startReady,
  input logic             outValid,
  input logic             outReady,
  input logic [wordW-1:0] outData,
  input logic             doneValid,
  input logic             doneReady
);

  int failCount = 0;

  resetQuiet: assert property (@(posedge clock)
    !rstN |-> !outValid && !doneValid && !loadReady && !startReady)
    else begin
      $error("Handshake flag high during reset");
      failCount++;
    end

  // Output word frozen under back-pressure
  outHold: assert property (@(posedge clock) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outData))
    else begin
      $error("outValid or outData changed before outReady");
      failCount++;
    end

  doneHold: assert property (@(posedge clock) disable iff (!rstN)
    doneValid && !doneReady |=> doneValid)
    else begin
      $error("doneValid dropped before doneReady");
      failCount++;
    end

endmodule

`default_nettype wire

//--- tb/cpuTb.sv
// CPU testbench: clock, reset, LFSR, program builder with ISA model, load/start/output/done handshakes, watchdog
`timescale 1ns/100ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

  localparam int memAddrW = 9;

  logic                clock;
  logic                rstN;
  logic                loadValid;
  logic [memAddrW-1:0] loadAddr;
  logic [wordW-1:0]    loadData;
  logic                loadReady;
  logic                startValid;
  logic [memAddrW-1:0] startPc;
  logic                startReady;
  logic                outValid;
  logic [wordW-1:0]    outData;
  logic                outReady;
  logic                doneValid;
  logic                doneReady;

  logic [31:0]         lfsrState = 32'h488f;
  logic [wordW-1:0]    regM [16];             // Register model
  logic [wordW-1:0]    memM [2**memAddrW];    // Data memory model
  logic [wordW-1:0]    hiM;
  logic [wordW-1:0]    loM;
  logic [wordW-1:0]    expQ [$];              // Expected outputs
  logic [memAddrW-1:0] imgAddr [$];           // Words to load before start
  logic [wordW-1:0]    imgData [$];
  int                  pcNext;
  logic [memAddrW-1:0] progStart;
  int                  errors = 0;
  int                  outErrors = 0;
  int                  busyErrors = 0;
  int                  nTests = 0;
  int                  nFailed = 0;
  int                  budget = 200;          // Reset plus margin, grows per test
  int                  cycles = 0;
  logic                busy = 1'b0;
  logic                stallMode = 1'b0;

  opcodeT aluOps [6] = '{opAdd, opSub, opAnd, opOr, opShl, opShr};

  always #2 clock = ~clock;

  cpuTop #(.memAddrW(memAddrW)) dut_i (
    .clock, .rstN, .loadValid, .loadAddr, .loadData, .loadReady,
    .startValid, .startPc, .startReady, .outValid, .outData, .outReady,
    .doneValid, .doneReady
  );

  bind cpuTop cpuTop_props props_i (
    .clock, .rstN, .loadReady, .startReady, .outValid, .outReady,
    .outData, .doneValid, .doneReady
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      r = {r[30:0], lfsrState[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] encode(input opcodeT op, input int ra, input int rb,
                                         input int rc, input int c);
    return {op, 4'(ra), 4'(rb), 4'(rc), 15'(c)};
  endfunction

  function automatic int errTotal();
    return errors + outErrors + busyErrors + dut_i.props_i.failCount;
  endfunction

  task automatic newProgram(input int base);
    imgAddr.delete();
    imgData.delete();
    pcNext = base;
    progStart = 9'(base);
  endtask

  task automatic preload(input logic [memAddrW-1:0] addr, input logic [wordW-1:0] value);
    imgAddr.push_back(addr);
    imgData.push_back(value);
    memM[addr] = value;
  endtask

  // Appends one instruction and applies its effect to the model
  task automatic emit(input opcodeT op, input int ra, input int rb, input int rc, input int c);
    logic [wordW-1:0]          cx;
    logic [wordW-1:0]          bv;
    logic [wordW-1:0]          cv;
    logic [memAddrW-1:0]       addr;
    logic signed [2*wordW-1:0] prod;
    cx = {{(wordW-cWidth){c[cWidth-1]}}, c[cWidth-1:0]};
    bv = regM[rb];
    cv = regM[rc];
    addr = (rb == 0) ? cx[memAddrW-1:0] : bv[memAddrW-1:0] + cx[memAddrW-1:0];
    prod = $signed({{wordW{bv[wordW-1]}}, bv}) * $signed({{wordW{cv[wordW-1]}}, cv});
    case (op)
      opLd:    regM[ra] = memM[addr];
      opSt:    memM[addr] = regM[ra];
      opAddi:  regM[ra] = bv + cx;
      opAdd:   regM[ra] = bv + cv;
      opSub:   regM[ra] = bv - cv;
      opAnd:   regM[ra] = bv & cv;
      opOr:    regM[ra] = bv | cv;
      opShl:   regM[ra] = bv << cv[4:0];
      opShr:   regM[ra] = bv >> cv[4:0];
      opMul: begin
        hiM = prod[2*wordW-1:wordW];
        loM = prod[wordW-1:0];
      end
      opMfhi:  regM[ra] = hiM;
      opMflo:  regM[ra] = loM;
      opOut:   expQ.push_back(regM[ra]);
      default: ;
    endcase
    imgAddr.push_back(9'(pcNext));
    imgData.push_back(encode(op, ra, rb, rc, c));
    pcNext++;
  endtask

  task automatic loadWord(input logic [memAddrW-1:0] addr, input logic [wordW-1:0] data);
    loadValid = 1'b1;
    loadAddr  = addr;
    loadData  = data;
    do @(posedge clock); while (!loadReady);
    @(negedge clock);
    loadValid = 1'b0;
  endtask

  task automatic runProgram(input string name, input logic stall);
    int errBefore;
    int doneDelay;
    errBefore = errTotal();
    doneDelay = int'(randBits(2));
    budget += imgData.size() * 8 + expQ.size() * 32 + 50;
    for (int k = 0; k < imgData.size(); k++) begin
      loadWord(imgAddr[k], imgData[k]);
    end
    stallMode  = stall;
    startValid = 1'b1;
    startPc    = progStart;
    do @(posedge clock); while (!startReady);
    @(negedge clock);
    startValid = 1'b0;
    busy       = 1'b1;
    do @(posedge clock); while (!doneValid);
    repeat (doneDelay) begin  // Hold off doneReady
      @(posedge clock);
      assert (doneValid) else begin
        $display("doneValid dropped at %0t before doneReady was given", $time);
        errors++;
      end
    end
    @(negedge clock);
    doneReady = 1'b1;
    @(posedge clock);
    @(negedge clock);
    doneReady = 1'b0;
    busy      = 1'b0;
    stallMode = 1'b0;
    assert (expQ.size() == 0) else begin
      $display("Program ended with %0d expected outputs never seen", expQ.size());
      errors++;
    end
    expQ.delete();
    nTests++;
    if (errTotal() > errBefore) begin
      nFailed++;
    end
    $display("Test %0d (%s): %s", nTests, name, (errTotal() > errBefore) ? "FAILED" : "ok");
  endtask

  // Output consumer, compares every accepted word with the queue head
  always @(posedge clock) begin
    if (rstN && outValid && outReady) begin
      assert (expQ.size() > 0) else begin
        $display("Output %h accepted at %0t with nothing expected", outData, $time);
        outErrors++;
      end
      if (expQ.size() > 0) begin
        assert (outData == expQ[0]) else begin
          $display("Mismatch at %0t: outData is %h, expected %h", $time, outData, expQ[0]);
          outErrors++;
        end
        void'(expQ.pop_front());
      end
    end
  end

  // Ready flags must stay low while a program runs
  always @(posedge clock) begin
    if (busy) begin
      assert (!loadReady && !startReady) else begin
        $display("Load or start ready raised at %0t while a program was running", $time);
        busyErrors++;
      end
    end
  end

  initial begin
    outReady = 1'b0;
    forever begin
      @(negedge clock);
      if (stallMode) begin
        outReady = (randBits(1) != 0);
      end else begin
        outReady = 1'b1;
      end
    end
  end

  initial begin
    while (cycles <= budget) begin
      @(posedge clock);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles", cycles);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int               i;
    int               rb;
    int               rc;
    logic [wordW-1:0] w;
    clock      = 1'b0;
    rstN       = 1'b0;
    loadValid  = 1'b0;
    loadAddr   = '0;
    loadData   = '0;
    startValid = 1'b0;
    startPc    = '0;
    doneReady  = 1'b0;
    for (i = 0; i < 16; i++) begin
      regM[i] = '0;
    end
    repeat (10) @(negedge clock);
    rstN = 1'b1;
    @(negedge clock);

    // addi from R0, then R0 written and still zero as a base
    newProgram(0);
    emit(opAddi, 1, 0, 0, -16);
    emit(opOut, 1, 0, 0, 0);
    emit(opAddi, 2, 0, 0, int'(randBits(15)));
    emit(opOut, 2, 0, 0, 0);
    emit(opSt, 1, 0, 0, 300);
    emit(opAddi, 0, 2, 0, 5);
    emit(opOut, 0, 0, 0, 0);
    emit(opLd, 3, 0, 0, 300);
    emit(opOut, 3, 0, 0, 0);
    emit(opSt, 2, 0, 0, 301);
    emit(opLd, 4, 0, 0, 301);
    emit(opOut, 4, 0, 0, 0);
    emit(opHalt, 0, 0, 0, 0);
    runProgram("R0 base and addi", 1'b0);

    newProgram(40);
    for (i = 0; i < 8; i++) begin
      preload(9'(320 + i), randBits(32));
      emit(opLd, i + 1, 0, 0, 320 + i);
    end
    for (i = 0; i < 12; i++) begin
      rb = 1 + int'(randBits(3));
      rc = 1 + int'(randBits(3));
      emit(aluOps[i % 6], 10, rb, rc, 0);
      emit(opOut, 10, 0, 0, 0);
    end
    emit(opHalt, 0, 0, 0, 0);
    runProgram("register ALU operations", 1'b0);

    newProgram(100);
    for (i = 0; i < 4; i++) begin
      w = randBits(32);
      if (i % 2 == 0) begin
        w[wordW-1] = 1'b1;  // Negative operand
      end
      preload(9'(340 + i), w);
      emit(opLd, i + 1, 0, 0, 340 + i);
    end
    emit(opMul, 0, 1, 2, 0);
    emit(opMfhi, 5, 0, 0, 0);
    emit(opMflo, 6, 0, 0, 0);
    emit(opOut, 5, 0, 0, 0);
    emit(opOut, 6, 0, 0, 0);
    emit(opMul, 0, 3, 4, 0);
    emit(opMflo, 7, 0, 0, 0);
    emit(opMfhi, 8, 0, 0, 0);
    emit(opOut, 7, 0, 0, 0);
    emit(opOut, 8, 0, 0, 0);
    emit(opHalt, 0, 0, 0, 0);
    runProgram("mul with mfhi and mflo", 1'b0);

    // Same address reached through two bases and offsets
    newProgram(140);
    for (i = 0; i < 2; i++) begin
      preload(9'(350 + i), randBits(32));
      emit(opLd, 1, 0, 0, 350 + i);
      emit(opAddi, 6, 9, 0, int'(randBits(8)));
      emit(opSt, 1, 6, 0, 400 + i - int'(regM[6][8:0]));
      emit(opAddi, 8, 6, 0, 1 + int'(randBits(6)));
      emit(opLd, 7, 8, 0, 400 + i - int'(regM[8][8:0]));
      emit(opOut, 7, 0, 0, 0);
    end
    emit(opHalt, 0, 0, 0, 0);
    runProgram("store then load", 1'b0);

    newProgram(180);
    for (i = 0; i < 6; i++) begin
      preload(9'(360 + i), randBits(32));
      emit(opLd, i + 1, 0, 0, 360 + i);
      emit(opOut, i + 1, 0, 0, 0);
    end
    for (i = 6; i > 0; i--) begin
      emit(opOut, i, 0, 0, 0);
    end
    emit(opHalt, 0, 0, 0, 0);
    runProgram("output back-pressure", 1'b1);

    newProgram(220);
    emit(opAddi, 11, 9, 0, int'(randBits(15)));
    emit(opAdd, 12, 11, 11, 0);
    emit(opOut, 12, 0, 0, 0);
    emit(opOut, 11, 0, 0, 0);
    emit(opHalt, 0, 0, 0, 0);
    runProgram("program after done", 1'b0);

    $display("Summary: %0d tests, %0d failed, %0d errors", nTests, nFailed, errTotal());
    if (errTotal() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/cpuPkg.sv
src/stepCounter.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/memoryUnit.sv
src/dataPath.sv
src/cpuTop.sv
tb/cpuTop_props.sv
tb/cpuTb.sv

//--- Makefile
# Verilator lint, simulation and clean for the CPU testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
